// ==== sim.f ====
hw/axil_xbar_pkg.sv
hw/rr_arbiter.sv
hw/route_fifo.sv
hw/xbar_target_port.sv
hw/xbar_initiator_port.sv
hw/axil_xbar_wr.sv
verification/axil_xbar_wr_props.sv
verification/tb_axil_xbar_wr.sv

// ==== Makefile ====
TOP := tb_axil_xbar_wr
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== verification/tb_axil_xbar_wr.sv ====
// Default DUT parameters only; targets are 4 KB memories that answer SLVERR when addr bit 11 is set
`default_nettype none

module tb_axil_xbar_wr import axil_xbar_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NONE = -1;
    localparam int GROUPS = 8;

    typedef struct {
        int         grp;
        int         init;
        logic [15:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        int         tgt;
        axil_resp_t resp;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] s_awaddr;
    logic [1:0]  s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic [63:0] s_wdata;
    logic [7:0]  s_wstrb;
    logic [3:0]  s_bresp, m_bresp;
    logic [31:0] m_awaddr;
    logic [1:0]  m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
    logic [63:0] m_wdata;
    logic [7:0]  m_wstrb;

    // Per-initiator drive values
    logic [15:0] aw_addr_d [2];
    logic [31:0] wdata_d [2];
    logic [3:0]  wstrb_d [2];
    logic        awvalid_d [2];
    logic        wvalid_d [2];
    logic        bready_d [2];

    // Target models
    logic [31:0] tmem [2][1024];
    logic [31:0] shadow [2][1024];
    bit          aw_have [2];
    logic [15:0] aw_addr_t [2];
    bit          b_pend [2];

    entry_t tbl[$];
    bit     stall;
    int     resp_errors, mem_errors, reset_errors;

    assign s_awaddr = {aw_addr_d[1], aw_addr_d[0]};
    assign s_wdata = {wdata_d[1], wdata_d[0]};
    assign s_wstrb = {wstrb_d[1], wstrb_d[0]};
    assign s_awvalid = {awvalid_d[1], awvalid_d[0]};
    assign s_wvalid = {wvalid_d[1], wvalid_d[0]};
    assign s_bready = {bready_d[1], bready_d[0]};

    always #4 clk = ~clk;

    axil_xbar_wr i_axil_xbar_wr (.*);

    function automatic logic [31:0] fill_word(int m, int w);
        return 32'h5a00_0000 ^ 32'(m * 4096 + w * 4);
    endfunction

    function automatic bit ready_roll();
        return stall ? ($urandom % 4 != 0) : 1'b1;
    endfunction

    task automatic add_entry(int g, int s, logic [15:0] a, logic [31:0] d, logic [3:0] st,
                             int t, axil_resp_t r);
        entry_t e;
        e = '{g, s, a, d, st, t, r};
        tbl.push_back(e);
    endtask

    // Targets take one address, then its data, then answer
    always @(negedge clk) begin
        if (rst) begin
            m_awready = '0;
            m_wready = '0;
            m_bvalid = '0;
            m_bresp = '0;
            aw_have = '{0, 0};
            b_pend = '{0, 0};
        end else begin
            for (int m = 0; m < 2; m++) begin
                m_awready[m] = !aw_have[m] && !b_pend[m] && ready_roll();
                m_wready[m] = aw_have[m] && !b_pend[m] && ready_roll();
                m_bvalid[m] = b_pend[m];
            end
            #3;
            for (int m = 0; m < 2; m++) begin
                if (m_bvalid[m] && m_bready[m]) begin
                    b_pend[m] = 0;
                end
                if (m_awvalid[m] && m_awready[m]) begin
                    aw_have[m] = 1;
                    aw_addr_t[m] = m_awaddr[m*16 +: 16];
                end
                if (m_wvalid[m] && m_wready[m]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (m_wstrb[m*4+b] && !aw_addr_t[m][11])
                            tmem[m][aw_addr_t[m][11:2]][b*8 +: 8] = m_wdata[m*32+b*8 +: 8];
                    end
                    m_bresp[m*2 +: 2] = aw_addr_t[m][11] ? SLVERR : OKAY;
                    aw_have[m] = 0;
                    b_pend[m] = 1;
                end
            end
        end
    end

    task automatic issue_writes(input int s, input int idx[$]);
        bit aw_done;
        bit w_done;
        if (idx.size() == 0) return;
        @(negedge clk);
        foreach (idx[k]) begin
            aw_addr_d[s] = tbl[idx[k]].addr;
            wdata_d[s] = tbl[idx[k]].data;
            wstrb_d[s] = tbl[idx[k]].strb;
            awvalid_d[s] = 1'b1;
            wvalid_d[s] = 1'b1;
            aw_done = 0;
            w_done = 0;
            while (!(aw_done && w_done)) begin
                #3;
                if (awvalid_d[s] && s_awready[s]) aw_done = 1;
                if (wvalid_d[s] && s_wready[s]) w_done = 1;
                @(negedge clk);
                if (aw_done) awvalid_d[s] = 1'b0;
                if (w_done) wvalid_d[s] = 1'b0;
            end
        end
    endtask

    // Responses must come back in issue order
    task automatic collect_responses(input int s, input int idx[$]);
        int k;
        k = 0;
        while (k < idx.size()) begin
            @(negedge clk);
            bready_d[s] = ready_roll();
            #3;
            if (s_bvalid[s] && bready_d[s]) begin
                assert (s_bresp[s*2 +: 2] == tbl[idx[k]].resp) else begin
                    $display("ERROR s_bresp[%0d] entry %0d: got %h expected %h",
                             s, idx[k], s_bresp[s*2 +: 2], tbl[idx[k]].resp);
                    resp_errors++;
                end
                k++;
            end
        end
        @(negedge clk);
        bready_d[s] = 1'b0;
    endtask

    task automatic run_group(input int g);
        int q0[$];
        int q1[$];
        foreach (tbl[i]) begin
            if (tbl[i].grp == g && tbl[i].init == 0) q0.push_back(i);
            if (tbl[i].grp == g && tbl[i].init == 1) q1.push_back(i);
        end
        fork
            issue_writes(0, q0);
            collect_responses(0, q0);
            issue_writes(1, q1);
            collect_responses(1, q1);
        join
    endtask

    task automatic check_reset();
        logic [11:0] outs;
        outs = {s_awready, s_wready, s_bvalid, m_awvalid, m_wvalid, m_bready};
        assert (outs == '0) else begin
            $display("ERROR %s: got %h expected %h",
                     "{s_awready,s_wready,s_bvalid,m_awvalid,m_wvalid,m_bready}",
                     outs, 12'h000);
            reset_errors++;
        end
    endtask

    initial begin
        void'($urandom(32'hfc76_df42));
        rst = 1'b1;
        stall = 0;
        m_awready = '0;
        m_wready = '0;
        m_bvalid = '0;
        m_bresp = '0;
        for (int s = 0; s < 2; s++) begin
            aw_addr_d[s] = '0;
            wdata_d[s] = '0;
            wstrb_d[s] = '0;
            awvalid_d[s] = 1'b0;
            wvalid_d[s] = 1'b0;
            bready_d[s] = 1'b0;
        end
        for (int m = 0; m < 2; m++) begin
            for (int w = 0; w < 1024; w++) begin
                tmem[m][w] = fill_word(m, w);
                shadow[m][w] = fill_word(m, w);
            end
        end
        add_entry(0, 0, 16'h0010, 32'h1122_3344, 4'hf, 0, OKAY);
        add_entry(1, 1, 16'h1020, 32'hcafe_f00d, 4'h3, 1, OKAY);
        add_entry(2, 0, 16'h0804, 32'hdead_beef, 4'hf, 0, SLVERR);
        add_entry(3, 1, 16'h2000, 32'h0bad_0bad, 4'hf, NONE, DECERR);
        add_entry(4, 0, 16'hf000, 32'h7777_7777, 4'hf, NONE, DECERR);
        add_entry(5, 0, 16'h1100, 32'ha1a2_a3a4, 4'hf, 1, OKAY);
        add_entry(5, 1, 16'h1104, 32'hb1b2_b3b4, 4'hc, 1, OKAY);
        add_entry(6, 0, 16'h0900, 32'hc1c2_c3c4, 4'hf, 0, SLVERR);
        add_entry(6, 1, 16'h0104, 32'hd1d2_d3d4, 4'h5, 0, OKAY);
        // Back-to-back from one initiator under random stalls
        add_entry(7, 0, 16'h0200, 32'h0101_0101, 4'hf, 0, OKAY);
        add_entry(7, 0, 16'h1200, 32'h0202_0202, 4'hf, 1, OKAY);
        add_entry(7, 0, 16'h3000, 32'h0303_0303, 4'hf, NONE, DECERR);
        add_entry(7, 0, 16'h1a00, 32'h0404_0404, 4'hf, 1, SLVERR);
        add_entry(7, 0, 16'h0204, 32'h0505_0505, 4'h9, 0, OKAY);
        add_entry(7, 0, 16'h0200, 32'h0606_0606, 4'h2, 0, OKAY);
        add_entry(7, 0, 16'h4444, 32'h0707_0707, 4'hf, NONE, DECERR);
        add_entry(7, 0, 16'h1208, 32'h0808_0808, 4'hf, 1, OKAY);
        add_entry(7, 0, 16'h0a08, 32'h0909_0909, 4'hf, 0, SLVERR);
        add_entry(7, 0, 16'h1210, 32'h0a0a_0a0a, 4'hf, 1, OKAY);

        // Expected memory contents from the table, strobed bytes of OKAY writes only
        foreach (tbl[i]) begin
            if (tbl[i].tgt != NONE && tbl[i].resp == OKAY) begin
                for (int b = 0; b < 4; b++) begin
                    if (tbl[i].strb[b])
                        shadow[tbl[i].tgt][tbl[i].addr[11:2]][b*8 +: 8] = tbl[i].data[b*8 +: 8];
                end
            end
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #3;
        check_reset();

        for (int g = 0; g < GROUPS; g++) begin
            stall = g == 7;
            run_group(g);
        end
        stall = 0;
        repeat (4) @(negedge clk);

        for (int m = 0; m < 2; m++) begin
            for (int w = 0; w < 1024; w++) begin
                assert (tmem[m][w] == shadow[m][w]) else begin
                    $display("ERROR tmem[%0d][%h]: got %h expected %h",
                             m, w, tmem[m][w], shadow[m][w]);
                    mem_errors++;
                end
            end
        end

        $display("Errors: response %0d, memory %0d, reset %0d",
                 resp_errors, mem_errors, reset_errors);
        if (resp_errors + mem_errors + reset_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog scaled to the table length
    initial begin
        #1;
        repeat (tbl.size() * 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", tbl.size() * 200);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/axil_xbar_wr_props.sv ====
// Bound to every axil_xbar_wr instance; handshake checks are off while rst is high
`default_nettype none

module axil_xbar_wr_props import axil_xbar_pkg::*; #(
    parameter int S_COUNT = 2,
    parameter int M_COUNT = 2,
    parameter int ADDR_W = 16,
    parameter int DATA_W = 32,
    parameter int M_ADDR_W = 12,
    localparam int STRB_W = DATA_W / 8,
    localparam int RESP_W = $bits(axil_resp_t),
    localparam int UPPER_W = ADDR_W - M_ADDR_W
) (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic [S_COUNT*ADDR_W-1:0] s_awaddr,
    input wire logic [S_COUNT-1:0]        s_awvalid,
    input wire logic [S_COUNT-1:0]        s_awready,
    input wire logic [S_COUNT*DATA_W-1:0] s_wdata,
    input wire logic [S_COUNT*STRB_W-1:0] s_wstrb,
    input wire logic [S_COUNT-1:0]        s_wvalid,
    input wire logic [S_COUNT-1:0]        s_wready,
    input wire logic [S_COUNT*RESP_W-1:0] s_bresp,
    input wire logic [S_COUNT-1:0]        s_bvalid,
    input wire logic [S_COUNT-1:0]        s_bready,
    input wire logic [M_COUNT*ADDR_W-1:0] m_awaddr,
    input wire logic [M_COUNT-1:0]        m_awvalid,
    input wire logic [M_COUNT-1:0]        m_awready,
    input wire logic [M_COUNT*DATA_W-1:0] m_wdata,
    input wire logic [M_COUNT*STRB_W-1:0] m_wstrb,
    input wire logic [M_COUNT-1:0]        m_wvalid,
    input wire logic [M_COUNT-1:0]        m_wready
);
    timeunit 1ns;
    timeprecision 1ps;

    for (genvar s = 0; s < S_COUNT; s++) begin : g_s
        a_s_aw_hold: assert property (@(posedge clk) disable iff (rst)
            s_awvalid[s] && !s_awready[s] |=> s_awvalid[s]
            && $stable(s_awaddr[s*ADDR_W +: ADDR_W])) else $error("s_awvalid dropped early");
        a_s_w_hold: assert property (@(posedge clk) disable iff (rst)
            s_wvalid[s] && !s_wready[s] |=> s_wvalid[s]
            && $stable(s_wdata[s*DATA_W +: DATA_W])
            && $stable(s_wstrb[s*STRB_W +: STRB_W])) else $error("s_wvalid dropped early");
        // Responses, local DECERR included, hold until the initiator takes them
        a_s_b_hold: assert property (@(posedge clk) disable iff (rst)
            s_bvalid[s] && !s_bready[s] |=> s_bvalid[s]
            && $stable(s_bresp[s*RESP_W +: RESP_W])) else $error("s_bvalid dropped early");
    end

    for (genvar m = 0; m < M_COUNT; m++) begin : g_m
        a_m_aw_hold: assert property (@(posedge clk) disable iff (rst)
            m_awvalid[m] && !m_awready[m] |=> m_awvalid[m]
            && $stable(m_awaddr[m*ADDR_W +: ADDR_W])) else $error("m_awvalid dropped early");
        a_m_w_hold: assert property (@(posedge clk) disable iff (rst)
            m_wvalid[m] && !m_wready[m] |=> m_wvalid[m]
            && $stable(m_wdata[m*DATA_W +: DATA_W])
            && $stable(m_wstrb[m*STRB_W +: STRB_W])) else $error("m_wvalid dropped early");
        // Only decoded windows may reach a target
        a_m_aw_window: assert property (@(posedge clk) disable iff (rst)
            m_awvalid[m] |-> m_awaddr[m*ADDR_W+M_ADDR_W +: UPPER_W] < UPPER_W'(M_COUNT))
            else $error("decode error address reached a target");
    end

    a_no_valid_in_rst: assert property (@(posedge clk)
        rst |-> s_awvalid == '0 && s_wvalid == '0) else $error("valid high during reset");

endmodule

bind axil_xbar_wr axil_xbar_wr_props #(
    .S_COUNT(S_COUNT),
    .M_COUNT(M_COUNT),
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W),
    .M_ADDR_W(M_ADDR_W)
) i_axil_xbar_wr_props (.*);

`default_nettype wire

// ==== hw/axil_xbar_wr.sv ====
// Write half only; targets sit at n * 2**M_ADDR_W, route FIFO depths must be powers of two
`default_nettype none

module axil_xbar_wr import axil_xbar_pkg::*; #(
    parameter int S_COUNT = 2,
    parameter int M_COUNT = 2,
    parameter int ADDR_W = 16,
    parameter int DATA_W = 32,
    parameter int M_ADDR_W = 12,
    parameter int ACCEPT_DEPTH = 8,
    parameter int ISSUE_DEPTH = 8,
    localparam int STRB_W = DATA_W / 8,
    localparam int RESP_W = $bits(axil_resp_t)
) (
    input  logic                        clk,
    input  logic                        rst,
    // Initiator side
    input  logic [S_COUNT*ADDR_W-1:0]   s_awaddr,
    input  logic [S_COUNT-1:0]          s_awvalid,
    output logic [S_COUNT-1:0]          s_awready,
    input  logic [S_COUNT*DATA_W-1:0]   s_wdata,
    input  logic [S_COUNT*STRB_W-1:0]   s_wstrb,
    input  logic [S_COUNT-1:0]          s_wvalid,
    output logic [S_COUNT-1:0]          s_wready,
    output logic [S_COUNT*RESP_W-1:0]   s_bresp,
    output logic [S_COUNT-1:0]          s_bvalid,
    input  logic [S_COUNT-1:0]          s_bready,
    // Target side
    output logic [M_COUNT*ADDR_W-1:0]   m_awaddr,
    output logic [M_COUNT-1:0]          m_awvalid,
    input  logic [M_COUNT-1:0]          m_awready,
    output logic [M_COUNT*DATA_W-1:0]   m_wdata,
    output logic [M_COUNT*STRB_W-1:0]   m_wstrb,
    output logic [M_COUNT-1:0]          m_wvalid,
    input  logic [M_COUNT-1:0]          m_wready,
    input  logic [M_COUNT*RESP_W-1:0]   m_bresp,
    input  logic [M_COUNT-1:0]          m_bvalid,
    output logic [M_COUNT-1:0]          m_bready
);

    // Request and ack matrices, initiator-major (_s) and target-major (_m)
    logic [S_COUNT*M_COUNT-1:0] aw_req_s;
    logic [S_COUNT*M_COUNT-1:0] aw_ack_s;
    logic [S_COUNT*M_COUNT-1:0] w_req_s;
    logic [S_COUNT*M_COUNT-1:0] w_ack_s;
    logic [S_COUNT*M_COUNT-1:0] b_req_s;
    logic [S_COUNT*M_COUNT-1:0] b_ack_s;
    logic [M_COUNT*S_COUNT-1:0] aw_req_m;
    logic [M_COUNT*S_COUNT-1:0] aw_ack_m;
    logic [M_COUNT*S_COUNT-1:0] w_req_m;
    logic [M_COUNT*S_COUNT-1:0] w_ack_m;
    logic [M_COUNT*S_COUNT-1:0] b_req_m;
    logic [M_COUNT*S_COUNT-1:0] b_ack_m;

    for (genvar s = 0; s < S_COUNT; s++) begin : g_init
        xbar_initiator_port #(
            .M_COUNT(M_COUNT),
            .ADDR_W(ADDR_W),
            .M_ADDR_W(M_ADDR_W),
            .ACCEPT_DEPTH(ACCEPT_DEPTH)
        ) i_xbar_initiator_port (
            .clk(clk),
            .rst(rst),
            .awaddr(s_awaddr[s*ADDR_W +: ADDR_W]),
            .awvalid(s_awvalid[s]),
            .awready(s_awready[s]),
            .wvalid(s_wvalid[s]),
            .wready(s_wready[s]),
            .bresp(s_bresp[s*RESP_W +: RESP_W]),
            .bvalid(s_bvalid[s]),
            .bready(s_bready[s]),
            .aw_req(aw_req_s[s*M_COUNT +: M_COUNT]),
            .aw_ack(aw_ack_s[s*M_COUNT +: M_COUNT]),
            .w_req(w_req_s[s*M_COUNT +: M_COUNT]),
            .w_ack(w_ack_s[s*M_COUNT +: M_COUNT]),
            .b_req(b_req_s[s*M_COUNT +: M_COUNT]),
            .b_ack(b_ack_s[s*M_COUNT +: M_COUNT]),
            .tgt_bresp(m_bresp)
        );

        // Transpose between the two port arrays
        for (genvar m = 0; m < M_COUNT; m++) begin : g_xpose
            assign aw_req_m[m*S_COUNT + s] = aw_req_s[s*M_COUNT + m];
            assign w_req_m[m*S_COUNT + s] = w_req_s[s*M_COUNT + m];
            assign b_req_m[m*S_COUNT + s] = b_req_s[s*M_COUNT + m];
            assign aw_ack_s[s*M_COUNT + m] = aw_ack_m[m*S_COUNT + s];
            assign w_ack_s[s*M_COUNT + m] = w_ack_m[m*S_COUNT + s];
            assign b_ack_s[s*M_COUNT + m] = b_ack_m[m*S_COUNT + s];
        end
    end

    for (genvar m = 0; m < M_COUNT; m++) begin : g_tgt
        xbar_target_port #(
            .S_COUNT(S_COUNT),
            .ADDR_W(ADDR_W),
            .DATA_W(DATA_W),
            .ISSUE_DEPTH(ISSUE_DEPTH)
        ) i_xbar_target_port (
            .clk(clk),
            .rst(rst),
            .aw_req(aw_req_m[m*S_COUNT +: S_COUNT]),
            .aw_ack(aw_ack_m[m*S_COUNT +: S_COUNT]),
            .w_req(w_req_m[m*S_COUNT +: S_COUNT]),
            .w_ack(w_ack_m[m*S_COUNT +: S_COUNT]),
            .b_req(b_req_m[m*S_COUNT +: S_COUNT]),
            .b_ack(b_ack_m[m*S_COUNT +: S_COUNT]),
            .init_awaddr(s_awaddr),
            .init_wdata(s_wdata),
            .init_wstrb(s_wstrb),
            .m_awaddr(m_awaddr[m*ADDR_W +: ADDR_W]),
            .m_awvalid(m_awvalid[m]),
            .m_awready(m_awready[m]),
            .m_wdata(m_wdata[m*DATA_W +: DATA_W]),
            .m_wstrb(m_wstrb[m*STRB_W +: STRB_W]),
            .m_wvalid(m_wvalid[m]),
            .m_wready(m_wready[m]),
            .m_bvalid(m_bvalid[m]),
            .m_bready(m_bready[m])
        );
    end

endmodule

`default_nettype wire

// ==== hw/xbar_initiator_port.sv ====
// Targets decode from address zero in windows of 2**M_ADDR_W bytes; one write data route at a time
`default_nettype none

module xbar_initiator_port import axil_xbar_pkg::*; #(
    parameter int M_COUNT = 2,
    parameter int ADDR_W = 16,
    parameter int M_ADDR_W = 12,
    parameter int ACCEPT_DEPTH = 8,
    localparam int RESP_W = $bits(axil_resp_t)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ADDR_W-1:0]         awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic                      wvalid,
    output logic                      wready,
    output axil_resp_t                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [M_COUNT-1:0]        aw_req,
    input  logic [M_COUNT-1:0]        aw_ack,
    output logic [M_COUNT-1:0]        w_req,
    input  logic [M_COUNT-1:0]        w_ack,
    output logic [M_COUNT-1:0]        b_req,
    input  logic [M_COUNT-1:0]        b_ack,
    input  logic [M_COUNT*RESP_W-1:0] tgt_bresp
);

    localparam int SEL_W = M_COUNT > 1 ? $clog2(M_COUNT) : 1;
    localparam int UPPER_W = ADDR_W - M_ADDR_W;
    localparam logic [UPPER_W-1:0] M_LIMIT = UPPER_W'(M_COUNT);

    logic [UPPER_W-1:0] upper;
    logic [SEL_W-1:0]   sel;
    logic               decerr;
    logic               admit;
    logic               dec_accept;
    wroute_state_t      route;
    logic [SEL_W-1:0]   w_sel;
    logic               aw_fire;
    logic               w_fire;
    logic               b_fire;
    logic               fifo_half;
    logic [SEL_W:0]     head_tag;
    logic               head_valid;
    logic               head_dec;
    logic [SEL_W-1:0]   head_sel;
    logic               dec_hold;

    // Address decode
    assign upper = awaddr[ADDR_W-1:M_ADDR_W];
    assign sel = upper[SEL_W-1:0];
    assign decerr = upper >= M_LIMIT;

    // Wait for FIFO room and for the previous write's data
    assign admit = awvalid && route == W_IDLE && !fifo_half;
    assign aw_req = (admit && !decerr) ? (M_COUNT'(1) << sel) : '0;
    assign awready = dec_accept || (admit && !decerr && aw_ack[sel]);
    assign aw_fire = awvalid && awready;

    // Decode errors are accepted locally one cycle after valid
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_accept <= 1'b0;
        end else begin
            dec_accept <= admit && decerr && !dec_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            route <= W_IDLE;
        end else begin
            case (route)
                W_IDLE: begin
                    if (aw_fire) begin
                        route <= decerr ? W_DROP : W_FORWARD;
                    end
                end
                W_FORWARD, W_DROP: begin
                    if (w_fire) begin
                        route <= W_IDLE;
                    end
                end
                default: route <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            w_sel <= sel;
        end
    end

    // Write data steering
    assign w_req = (route == W_FORWARD && wvalid) ? (M_COUNT'(1) << w_sel) : '0;
    assign wready = route == W_DROP || (route == W_FORWARD && w_ack[w_sel]);
    assign w_fire = wvalid && wready;

    // Tag is {decode error, target index}
    route_fifo #(
        .TAG_W(SEL_W + 1),
        .DEPTH(ACCEPT_DEPTH)
    ) i_route_fifo (
        .clk(clk),
        .rst(rst),
        .push(aw_fire),
        .push_tag({decerr, sel}),
        .full_half(fifo_half),
        .pop(b_fire),
        .head_tag(head_tag),
        .head_valid(head_valid)
    );

    assign head_dec = head_tag[SEL_W];
    assign head_sel = head_tag[SEL_W-1:0];

    // A local DECERR waits until its data is dropped, then holds until bready
    assign bvalid = head_valid
                    && (head_dec ? (route != W_DROP || dec_hold) : b_ack[head_sel]);
    assign bresp = head_dec ? DECERR : axil_resp_t'(tgt_bresp[head_sel*RESP_W +: RESP_W]);
    assign b_req = (head_valid && !head_dec && bready) ? (M_COUNT'(1) << head_sel) : '0;
    assign b_fire = bvalid && bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_hold <= 1'b0;
        end else begin
            dec_hold <= head_dec && bvalid && !bready;
        end
    end

endmodule

`default_nettype wire

// ==== hw/xbar_target_port.sv ====
// One address per target until its data is sent; the target must answer in address order
`default_nettype none

module xbar_target_port import axil_xbar_pkg::*; #(
    parameter int S_COUNT = 2,
    parameter int ADDR_W = 16,
    parameter int DATA_W = 32,
    parameter int ISSUE_DEPTH = 8,
    localparam int STRB_W = DATA_W / 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [S_COUNT-1:0]          aw_req,
    output logic [S_COUNT-1:0]          aw_ack,
    input  logic [S_COUNT-1:0]          w_req,
    output logic [S_COUNT-1:0]          w_ack,
    input  logic [S_COUNT-1:0]          b_req,
    output logic [S_COUNT-1:0]          b_ack,
    input  logic [S_COUNT*ADDR_W-1:0]   init_awaddr,
    input  logic [S_COUNT*DATA_W-1:0]   init_wdata,
    input  logic [S_COUNT*STRB_W-1:0]   init_wstrb,
    output logic [ADDR_W-1:0]           m_awaddr,
    output logic                        m_awvalid,
    input  logic                        m_awready,
    output logic [DATA_W-1:0]           m_wdata,
    output logic [STRB_W-1:0]           m_wstrb,
    output logic                        m_wvalid,
    input  logic                        m_wready,
    input  logic                        m_bvalid,
    output logic                        m_bready
);

    localparam int IDX_W = S_COUNT > 1 ? $clog2(S_COUNT) : 1;

    wroute_state_t      route;
    logic [IDX_W-1:0]   w_sel;
    logic [S_COUNT-1:0] arb_req;
    logic [S_COUNT-1:0] grant;
    logic               grant_valid;
    logic [IDX_W-1:0]   grant_index;
    logic               fifo_half;
    logic [IDX_W-1:0]   b_sel;
    logic               aw_fire;
    logic               w_fire;
    logic               b_fire;

    // New addresses only while the data channel is free and the FIFO has room
    assign arb_req = (route == W_IDLE && !fifo_half) ? aw_req : '0;

    rr_arbiter #(
        .PORTS(S_COUNT)
    ) i_rr_arbiter (
        .clk(clk),
        .rst(rst),
        .req(arb_req),
        .ack(aw_ack),
        .grant(grant),
        .grant_valid(grant_valid),
        .grant_index(grant_index)
    );

    // Address mux
    assign m_awaddr = init_awaddr[grant_index*ADDR_W +: ADDR_W];
    assign m_awvalid = grant_valid && |(grant & aw_req);
    assign aw_ack = (grant_valid && m_awready) ? (grant & aw_req) : '0;
    assign aw_fire = m_awvalid && m_awready;

    // Data route opens right after the address handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            route <= W_IDLE;
        end else if (aw_fire) begin
            route <= W_FORWARD;
        end else if (w_fire) begin
            route <= W_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            w_sel <= grant_index;
        end
    end

    // Data mux
    assign m_wdata = init_wdata[w_sel*DATA_W +: DATA_W];
    assign m_wstrb = init_wstrb[w_sel*STRB_W +: STRB_W];
    assign m_wvalid = route == W_FORWARD && w_req[w_sel];
    assign w_ack = (route == W_FORWARD && m_wready) ? (S_COUNT'(1) << w_sel) : '0;
    assign w_fire = m_wvalid && m_wready;

    // Initiator index of each accepted address, oldest at the head
    route_fifo #(
        .TAG_W(IDX_W),
        .DEPTH(ISSUE_DEPTH)
    ) i_route_fifo (
        .clk(clk),
        .rst(rst),
        .push(aw_fire),
        .push_tag(grant_index),
        .full_half(fifo_half),
        .pop(b_fire),
        .head_tag(b_sel),
        .head_valid()
    );

    // Response demux
    assign m_bready = b_req[b_sel];
    assign b_ack = m_bvalid ? (S_COUNT'(1) << b_sel) : '0;
    assign b_fire = m_bvalid && m_bready;

endmodule

`default_nettype wire

// ==== hw/route_fifo.sv ====
// DEPTH is a power of two, at least 2; push is not checked against full, users stop at half full
`default_nettype none

module route_fifo #(
    parameter int TAG_W = 2,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [TAG_W-1:0] push_tag,
    output logic             full_half,
    input  logic             pop,
    output logic [TAG_W-1:0] head_tag,
    output logic             head_valid
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W+1:0] HALF = (PTR_W + 2)'(DEPTH / 2);

    logic [TAG_W-1:0] mem [DEPTH];
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic [PTR_W:0]   ptr_diff;
    logic [PTR_W+1:0] level;
    logic             store_empty;
    logic             head_load;
    logic             store_pop;
    logic             store_push;
    logic             bypass;

    assign store_empty = wr_ptr == rd_ptr;
    assign head_load = !head_valid || pop;
    assign store_pop = head_load && !store_empty;
    // Empty FIFO: the tag goes straight into the head register
    assign bypass = head_load && store_empty && push;
    assign store_push = push && !bypass;

    // Head register counts as one entry
    assign ptr_diff = wr_ptr - rd_ptr;
    assign level = {1'b0, ptr_diff} + {{(PTR_W + 1){1'b0}}, head_valid};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            head_valid <= 1'b0;
            full_half <= 1'b0;
        end else begin
            if (store_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (store_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (head_load) begin
                head_valid <= store_pop || bypass;
            end
            full_half <= level >= HALF;
        end
    end

    always_ff @(posedge clk) begin
        if (store_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_tag;
        end
        if (store_pop) begin
            head_tag <= mem[rd_ptr[PTR_W-1:0]];
        end else if (bypass) begin
            head_tag <= push_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rr_arbiter.sv ====
// Grant is registered and held until ack; a released grant re-arbitrates one cycle later
`default_nettype none

module rr_arbiter #(
    parameter int PORTS = 2,
    localparam int IDX_W = PORTS > 1 ? $clog2(PORTS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [PORTS-1:0] req,
    input  logic [PORTS-1:0] ack,
    output logic [PORTS-1:0] grant,
    output logic             grant_valid,
    output logic [IDX_W-1:0] grant_index
);

    // Ports above the last winner go first
    logic [PORTS-1:0] prio_mask;
    logic [PORTS-1:0] next_grant;
    logic [IDX_W-1:0] next_index;
    logic             next_found;

    always_comb begin
        next_grant = '0;
        next_index = '0;
        next_found = 1'b0;
        for (int i = 0; i < PORTS; i++) begin
            if (!next_found && req[i] && prio_mask[i]) begin
                next_grant[i] = 1'b1;
                next_index = IDX_W'(i);
                next_found = 1'b1;
            end
        end
        // Nobody above the winner, wrap to the lowest request
        for (int i = 0; i < PORTS; i++) begin
            if (!next_found && req[i]) begin
                next_grant[i] = 1'b1;
                next_index = IDX_W'(i);
                next_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant <= '0;
            grant_index <= '0;
            prio_mask <= '1;
        end else if (grant_valid) begin
            if (|(grant & ack)) begin
                grant_valid <= 1'b0;
                grant <= '0;
                prio_mask <= ~(grant | (grant - 1'b1));
            end
        end else if (next_found) begin
            grant_valid <= 1'b1;
            grant <= next_grant;
            grant_index <= next_index;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axil_xbar_pkg.sv ====
// Response codes use the AXI BRESP encoding; route states are only used inside the crossbar
`default_nettype none

package axil_xbar_pkg;

    // Write response codes, same values as the AXI BRESP field
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_t;

    // Ownership of a write data channel
    typedef enum logic [1:0] {
        // No address owns the data channel
        W_IDLE    = 2'b00,
        // Data goes to the selected port
        W_FORWARD = 2'b01,
        // Data is consumed locally after a decode error
        W_DROP    = 2'b10
    } wroute_state_t;

endpackage

`default_nettype wire
